// File: hw/oric_defines.svh
`ifndef ORIC_DEFINES_SVH
`define ORIC_DEFINES_SVH

// Width of one VGA colour channel at the board pins
`define COLOR_BITS 6

// Width of the audio sample from the sound generator
`define DAC_BITS 16

`endif

// File: hw/oric_pkg.sv
package oric_pkg;

	// The eight Oric colours, coded as {b,g,r}
	typedef enum logic [2:0] {
		black   = 3'd0,
		red     = 3'd1,
		green   = 3'd2,
		yellow  = 3'd3,
		blue    = 3'd4,
		magenta = 3'd5,
		cyan    = 3'd6,
		white   = 3'd7
	} oric_color_t;

	// Darkening applied to odd lines
	typedef enum logic [1:0] {
		sl_none = 2'd0, // Lines pass unchanged
		sl_25   = 2'd1,
		sl_50   = 2'd2,
		sl_75   = 2'd3
	} scanline_mode_t;

endpackage

// File: hw/line_tracker.sv
`timescale 1ns/1ps

module line_tracker (
	input  logic clk_24,
	input  logic rst_n,
	input  logic hs,
	input  logic vs,
	output logic odd_line,
	output logic hs_d,
	output logic vs_d
);

	logic hs_prev;
	logic hs_rise;
	logic parity;
	logic parity_next;

	assign hs_rise = hs & ~hs_prev;

	// Vertical sync wins over a horizontal edge in the same cycle
	always_comb begin
		if (vs)
			parity_next = 1'b0;
		else if (hs_rise)
			parity_next = ~parity;
		else
			parity_next = parity;
	end

	always_ff @(posedge clk_24) begin
		if (!rst_n) begin
			hs_prev <= 1'b0;
			parity  <= 1'b0;
		end else begin
			hs_prev <= hs;
			parity  <= parity_next;
		end
	end

	// Syncs take the same single register stage as the colour expander
	always_ff @(posedge clk_24) begin
		if (!rst_n) begin
			hs_d <= 1'b0;
			vs_d <= 1'b0;
		end else begin
			hs_d <= hs;
			vs_d <= vs;
		end
	end

	assign odd_line = parity; // Parity register lines up with the expander output

	// A frame always starts on an even line
	frame_starts_even: assert property (
		@(posedge clk_24) disable iff (!rst_n)
		$past(vs) |-> !odd_line
	) else $error("odd_line high after vs");

endmodule

// File: hw/color_expander.sv
`timescale 1ns/1ps
`include "oric_defines.svh"

module color_expander (
	input  logic                   clk_24,
	input  logic                   rst_n,
	input  logic                   r,
	input  logic                   g,
	input  logic                   b,
	input  logic                   hs,
	input  logic                   vs,
	output logic [`COLOR_BITS-1:0] exp_r,
	output logic [`COLOR_BITS-1:0] exp_g,
	output logic [`COLOR_BITS-1:0] exp_b
);

	import oric_pkg::*;

	localparam logic [`COLOR_BITS-1:0] FULL = '1;
	localparam logic [`COLOR_BITS-1:0] NONE = '0;

	oric_color_t                     index;
	logic        [3*`COLOR_BITS-1:0] rgb;

	assign index = oric_color_t'({b, g, r});

	// Palette lookup, packed as {r,g,b}
	always_comb begin
		case (index)
			black:   rgb = {NONE, NONE, NONE};
			red:     rgb = {FULL, NONE, NONE};
			green:   rgb = {NONE, FULL, NONE};
			yellow:  rgb = {FULL, FULL, NONE};
			blue:    rgb = {NONE, NONE, FULL};
			magenta: rgb = {FULL, NONE, FULL};
			cyan:    rgb = {NONE, FULL, FULL};
			default: rgb = {FULL, FULL, FULL}; // White
		endcase
	end

	always_ff @(posedge clk_24) begin
		if (!rst_n || hs || vs) begin // Blank during either sync
			{exp_r, exp_g, exp_b} <= '0;
		end else begin
			{exp_r, exp_g, exp_b} <= rgb;
		end
	end

	channels_full_scale: assert property (
		@(posedge clk_24) disable iff (!rst_n)
		(exp_r == NONE || exp_r == FULL) && (exp_g == NONE || exp_g == FULL) &&
		(exp_b == NONE || exp_b == FULL)
	) else $error("expanded colour not 0 or 63");

endmodule

// File: hw/scanline_mixer.sv
`timescale 1ns/1ps
`include "oric_defines.svh"

module scanline_mixer (
	input  logic                     clk_24,
	input  logic                     rst_n,
	input  oric_pkg::scanline_mode_t scanline_mode,
	input  logic                     odd_line,
	input  logic                     hs_d,
	input  logic                     vs_d,
	input  logic [`COLOR_BITS-1:0]   exp_r,
	input  logic [`COLOR_BITS-1:0]   exp_g,
	input  logic [`COLOR_BITS-1:0]   exp_b,
	output logic [`COLOR_BITS-1:0]   VGA_R,
	output logic [`COLOR_BITS-1:0]   VGA_G,
	output logic [`COLOR_BITS-1:0]   VGA_B,
	output logic                     VGA_HS,
	output logic                     VGA_VS
);

	import oric_pkg::*;

	logic [`COLOR_BITS-1:0] mix_r;
	logic [`COLOR_BITS-1:0] mix_g;
	logic [`COLOR_BITS-1:0] mix_b;

	// CRT style darkening of one channel
	function automatic logic [`COLOR_BITS-1:0] darken(
		input logic [`COLOR_BITS-1:0] c,
		input scanline_mode_t         mode
	);
		case (mode)
			sl_25:   darken = c - (c >> 2);
			sl_50:   darken = c >> 1;
			sl_75:   darken = c >> 2;
			default: darken = c;
		endcase
	endfunction

	assign mix_r = odd_line ? darken(exp_r, scanline_mode) : exp_r;
	assign mix_g = odd_line ? darken(exp_g, scanline_mode) : exp_g;
	assign mix_b = odd_line ? darken(exp_b, scanline_mode) : exp_b;

	always_ff @(posedge clk_24) begin
		if (!rst_n) begin
			VGA_R  <= '0;
			VGA_G  <= '0;
			VGA_B  <= '0;
			VGA_HS <= 1'b0;
			VGA_VS <= 1'b0;
		end else begin
			VGA_R  <= mix_r;
			VGA_G  <= mix_g;
			VGA_B  <= mix_b;
			VGA_HS <= hs_d; // Second sync stage, matching the colour
			VGA_VS <= vs_d;
		end
	end

	even_line_passes: assert property (
		@(posedge clk_24) disable iff (!rst_n)
		!odd_line |=> (VGA_R == $past(exp_r)) && (VGA_G == $past(exp_g)) &&
			(VGA_B == $past(exp_b))
	) else $error("even line colour altered");

endmodule

// File: hw/sigma_delta_dac.sv
`timescale 1ns/1ps
`include "oric_defines.svh"

module sigma_delta_dac (
	input  logic                 clk_24,
	input  logic                 rst_n,
	input  logic [`DAC_BITS-1:0] sample,
	output logic                 dac_out
);

	logic [`DAC_BITS:0] acc; // Top bit holds the carry of the last addition

	// Only the lower bits feed back, so the carry rate tracks sample/2^16
	always_ff @(posedge clk_24) begin
		if (!rst_n)
			acc <= '0;
		else
			acc <= {1'b0, acc[`DAC_BITS-1:0]} + {1'b0, sample};
	end

	assign dac_out = acc[`DAC_BITS];

endmodule

// File: hw/oric_av_out.sv
`timescale 1ns/1ps
`include "oric_defines.svh"

module oric_av_out (
	input  logic                     clk_24,
	input  logic                     rst_n,
	input  logic                     r,
	input  logic                     g,
	input  logic                     b,
	input  logic                     hs,
	input  logic                     vs,
	input  oric_pkg::scanline_mode_t scanline_mode,
	input  logic [`DAC_BITS-1:0]     audio,
	output logic [`COLOR_BITS-1:0]   VGA_R,
	output logic [`COLOR_BITS-1:0]   VGA_G,
	output logic [`COLOR_BITS-1:0]   VGA_B,
	output logic                     VGA_HS,
	output logic                     VGA_VS,
	output logic                     AUDIO_L,
	output logic                     AUDIO_R
);

	logic                   odd_line;
	logic                   hs_d;
	logic                   vs_d;
	logic [`COLOR_BITS-1:0] exp_r;
	logic [`COLOR_BITS-1:0] exp_g;
	logic [`COLOR_BITS-1:0] exp_b;
	logic                   dac_out;

	// Tracker and expander both take one cycle, so their outputs meet aligned
	line_tracker line_tracker_i (
		.clk_24   (clk_24),
		.rst_n    (rst_n),
		.hs       (hs),
		.vs       (vs),
		.odd_line (odd_line),
		.hs_d     (hs_d),
		.vs_d     (vs_d)
	);

	color_expander color_expander_i (
		.clk_24 (clk_24),
		.rst_n  (rst_n),
		.r      (r),
		.g      (g),
		.b      (b),
		.hs     (hs),
		.vs     (vs),
		.exp_r  (exp_r),
		.exp_g  (exp_g),
		.exp_b  (exp_b)
	);

	scanline_mixer scanline_mixer_i (
		.clk_24        (clk_24),
		.rst_n         (rst_n),
		.scanline_mode (scanline_mode),
		.odd_line      (odd_line),
		.hs_d          (hs_d),
		.vs_d          (vs_d),
		.exp_r         (exp_r),
		.exp_g         (exp_g),
		.exp_b         (exp_b),
		.VGA_R         (VGA_R),
		.VGA_G         (VGA_G),
		.VGA_B         (VGA_B),
		.VGA_HS        (VGA_HS),
		.VGA_VS        (VGA_VS)
	);

	sigma_delta_dac sigma_delta_dac_i (
		.clk_24  (clk_24),
		.rst_n   (rst_n),
		.sample  (audio),
		.dac_out (dac_out)
	);

	assign AUDIO_L = dac_out;
	assign AUDIO_R = dac_out; // Mono source on both pins

endmodule

// File: verif/oric_av_out_tb.sv
`timescale 1ns/1ps
`include "oric_defines.svh"

module oric_av_out_tb;

	import oric_pkg::*;

	localparam int RESET_CYCLES   = 8;
	localparam int PALETTE_PIXELS = 64;
	localparam int BLANK_PIXELS   = 48;
	localparam int LINES_PER_MODE = 7;
	localparam int HS_WIDTH       = 2;
	localparam int LINE_PIXELS    = 10;
	localparam int VS_WIDTH       = 3;
	localparam int AUDIO_WINDOW   = 1024;
	localparam int FLUSH_CYCLES   = 3;
	// Clock edges used by all tests, counted from the tasks below
	localparam int TEST_CYCLES    = 3 * (RESET_CYCLES + 1) + 4 + PALETTE_PIXELS +
		BLANK_PIXELS + 4 * (1 + LINES_PER_MODE * (HS_WIDTH + LINE_PIXELS) + VS_WIDTH + 5) +
		2 * (AUDIO_WINDOW + 1) + 5 * FLUSH_CYCLES;
	localparam int TIMEOUT_CYCLES = TEST_CYCLES + TEST_CYCLES / 5;

	logic                   clk;
	logic                   rst_n;
	logic                   r;
	logic                   g;
	logic                   b;
	logic                   hs;
	logic                   vs;
	scanline_mode_t         scanline_mode;
	logic [`DAC_BITS-1:0]   audio;
	logic [`COLOR_BITS-1:0] VGA_R;
	logic [`COLOR_BITS-1:0] VGA_G;
	logic [`COLOR_BITS-1:0] VGA_B;
	logic                   VGA_HS;
	logic                   VGA_VS;
	logic                   AUDIO_L;
	logic                   AUDIO_R;

	logic [31:0] lfsr_state;
	int          err_count;
	int          test_count;
	int          test_start_errs;

	logic                   hs_prev_m;
	logic                   parity_m; // Parity of the pixel in the history stage
	logic [2:0]             hist_rgb; // Last sampled pixel as {b,g,r}
	logic                   hist_hs;
	logic                   hist_vs;
	logic [`COLOR_BITS-1:0] want_r;
	logic [`COLOR_BITS-1:0] want_g;
	logic [`COLOR_BITS-1:0] want_b;
	logic                   want_hs;
	logic                   want_vs;

	oric_av_out oric_av_out_i (
		.clk_24        (clk),
		.rst_n         (rst_n),
		.r             (r),
		.g             (g),
		.b             (b),
		.hs            (hs),
		.vs            (vs),
		.scanline_mode (scanline_mode),
		.audio         (audio),
		.VGA_R         (VGA_R),
		.VGA_G         (VGA_G),
		.VGA_B         (VGA_B),
		.VGA_HS        (VGA_HS),
		.VGA_VS        (VGA_VS),
		.AUDIO_L       (AUDIO_L),
		.AUDIO_R       (AUDIO_R)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic random_bit();
		lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
		return lfsr_state[0];
	endfunction

	function automatic logic [2:0] random_color();
		logic [2:0] c;
		c[0] = random_bit();
		c[1] = random_bit();
		c[2] = random_bit();
		return c;
	endfunction

	// A rising hs starts a new line, a frame restarts on an even line
	function automatic logic next_parity(input logic p, input logic h, input logic h_prev,
		input logic v);
		if (v)
			return 1'b0;
		if (h && !h_prev)
			return ~p;
		return p;
	endfunction

	function automatic logic [`COLOR_BITS-1:0] expect_channel(input logic on,
		input logic blank, input logic odd, input scanline_mode_t mode);
		logic [`COLOR_BITS-1:0] c;
		c = (on && !blank) ? '1 : '0;
		if (!odd)
			return c;
		case (mode)
			sl_25:   return c - c / 4;
			sl_50:   return c / 2;
			sl_75:   return c / 4;
			default: return c;
		endcase
	endfunction

	// Reference model with a two deep history, so want_* line up with the pins
	always @(posedge clk) begin
		if (!rst_n) begin
			hs_prev_m <= 1'b0;
			parity_m  <= 1'b0;
			hist_rgb  <= '0;
			hist_hs   <= 1'b0;
			hist_vs   <= 1'b0;
			want_r    <= '0;
			want_g    <= '0;
			want_b    <= '0;
			want_hs   <= 1'b0;
			want_vs   <= 1'b0;
		end else begin
			hs_prev_m <= hs;
			parity_m  <= next_parity(parity_m, hs, hs_prev_m, vs);
			hist_rgb  <= {b, g, r};
			hist_hs   <= hs;
			hist_vs   <= vs;
			want_r    <= expect_channel(hist_rgb[0], hist_hs | hist_vs, parity_m, scanline_mode);
			want_g    <= expect_channel(hist_rgb[1], hist_hs | hist_vs, parity_m, scanline_mode);
			want_b    <= expect_channel(hist_rgb[2], hist_hs | hist_vs, parity_m, scanline_mode);
			want_hs   <= hist_hs;
			want_vs   <= hist_vs;
		end
	end

	task automatic report_mismatch(input string name, input int expected, input int actual);
		err_count++;
		$display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
	endtask

	vga_r_matches: assert property (@(posedge clk) disable iff (!rst_n) VGA_R == want_r)
		else report_mismatch("VGA_R", int'($sampled(want_r)), int'($sampled(VGA_R)));
	vga_g_matches: assert property (@(posedge clk) disable iff (!rst_n) VGA_G == want_g)
		else report_mismatch("VGA_G", int'($sampled(want_g)), int'($sampled(VGA_G)));
	vga_b_matches: assert property (@(posedge clk) disable iff (!rst_n) VGA_B == want_b)
		else report_mismatch("VGA_B", int'($sampled(want_b)), int'($sampled(VGA_B)));
	vga_hs_matches: assert property (@(posedge clk) disable iff (!rst_n) VGA_HS == want_hs)
		else report_mismatch("VGA_HS", int'($sampled(want_hs)), int'($sampled(VGA_HS)));
	vga_vs_matches: assert property (@(posedge clk) disable iff (!rst_n) VGA_VS == want_vs)
		else report_mismatch("VGA_VS", int'($sampled(want_vs)), int'($sampled(VGA_VS)));
	audio_pins_equal: assert property (@(posedge clk) AUDIO_R == AUDIO_L)
		else report_mismatch("AUDIO_R", int'($sampled(AUDIO_L)), int'($sampled(AUDIO_R)));

	task automatic drive_pixel(input logic [2:0] color, input logic hs_v, input logic vs_v);
		@(posedge clk);
		r  <= color[0];
		g  <= color[1];
		b  <= color[2];
		hs <= hs_v;
		vs <= vs_v;
	endtask

	task automatic apply_reset();
		rst_n <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic finish_test(input string name);
		repeat (FLUSH_CYCLES) @(posedge clk); // Last pixels still in the pipeline
		test_count++;
		$display("Test %0d %s: %0d errors", test_count, name, err_count - test_start_errs);
	endtask

	task automatic check_reset_state();
		@(negedge clk);
		assert (VGA_R == '0 && VGA_G == '0 && VGA_B == '0 && !VGA_HS && !VGA_VS &&
			!AUDIO_L && !AUDIO_R) else begin
			err_count++;
			$display("Outputs were not all zero right after reset at %0t ns", $time);
		end
		repeat (4) drive_pixel(white, 1'b0, 1'b0);
	endtask

	task automatic run_blanking();
		logic [2:0] color;
		logic       hs_v;
		logic       vs_v;
		repeat (BLANK_PIXELS) begin
			color = random_color();
			hs_v  = random_bit();
			vs_v  = random_bit() & random_bit(); // Vertical sync a quarter of the time
			drive_pixel(color, hs_v, vs_v);
		end
	endtask

	task automatic run_scanlines(input scanline_mode_t mode);
		@(posedge clk);
		scanline_mode <= mode;
		repeat (LINES_PER_MODE) begin
			repeat (HS_WIDTH) drive_pixel(random_color(), 1'b1, 1'b0);
			repeat (LINE_PIXELS) drive_pixel(random_color(), 1'b0, 1'b0);
		end
		repeat (VS_WIDTH) drive_pixel(black, 1'b0, 1'b1);
		repeat (4) drive_pixel(white, 1'b0, 1'b0);
		@(negedge clk);
		assert (VGA_R == '1 && VGA_G == '1 && VGA_B == '1) else begin
			err_count++;
			$display("Line after vertical sync was darkened at %0t ns", $time);
		end
		@(posedge clk);
	endtask

	task automatic check_audio_density(input logic [`DAC_BITS-1:0] v);
		int ones;
		int want;
		ones = 0;
		want = (AUDIO_WINDOW * int'(v)) >> `DAC_BITS;
		audio <= v;
		apply_reset();
		repeat (AUDIO_WINDOW) begin
			@(posedge clk);
			@(negedge clk);
			if (AUDIO_L)
				ones++;
		end
		@(posedge clk);
		assert (ones == want) else report_mismatch("AUDIO_L ones", want, ones);
	endtask

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the tests did not complete", cycles);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		lfsr_state      = 32'h8a50_9461;
		err_count       = 0;
		test_count      = 0;
		test_start_errs = 0;
		rst_n           = 1'b0;
		r               = 1'b0;
		g               = 1'b0;
		b               = 1'b0;
		hs              = 1'b0;
		vs              = 1'b0;
		scanline_mode   = sl_none;
		audio           = '0;
		apply_reset();

		test_start_errs = err_count;
		check_reset_state();
		finish_test("reset state");

		test_start_errs = err_count;
		repeat (PALETTE_PIXELS) drive_pixel(random_color(), 1'b0, 1'b0);
		finish_test("palette and latency");

		test_start_errs = err_count;
		run_blanking();
		finish_test("blanking and sync delay");

		test_start_errs = err_count;
		run_scanlines(sl_none);
		run_scanlines(sl_25);
		run_scanlines(sl_50);
		run_scanlines(sl_75);
		finish_test("scanlines");

		test_start_errs = err_count;
		check_audio_density(16'h4000);
		check_audio_density(16'hC000);
		finish_test("audio density");

		$display("Tests run: %0d, errors: %0d", test_count, err_count);
		if (err_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+hw
hw/oric_pkg.sv
hw/line_tracker.sv
hw/color_expander.sv
hw/scanline_mixer.sv
hw/sigma_delta_dac.sv
hw/oric_av_out.sv
verif/oric_av_out_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir &&
	verilator --binary --assert --timing -j 0 \
		--top-module oric_av_out_tb -f verilog.f -o sim > "$LOG" 2>&1 &&
	./obj_dir/sim >> "$LOG" 2>&1 ||
	{ cat "$LOG"; echo "Build or simulation stopped with an error"; exit 1; }

cat "$LOG"

grep -q "Finished with errors" "$LOG" &&
	{ echo "Simulation failed"; exit 1; }

grep -q "Finished with no errors" "$LOG" ||
	{ echo "No result line found in $LOG"; exit 1; }

echo "Simulation passed"
